// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lrelu_engine -f all.f

run: compile
	./obj_dir/Vtb_lrelu_engine > sim.log 2>&1; cat sim.log
	@if grep -q "Test FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test OK" sim.log; then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: all.f
lrelu_data_pkg.sv
lrelu_cfg_pkg.sv
cfg_loader.sv
position_decoder.sv
lrelu_datapath.sv
lrelu_engine.sv
lrelu_engine_chk.sv
tb_lrelu_engine.sv

// File: cfg_loader.sv
module cfg_loader
  import lrelu_cfg_pkg::*;
#(
  parameter int GROUPS = 2
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cfg_valid,
  input  logic      cfg_1x1,
  input  logic      cfg_restart,
  input  cfg_word_t cfg_data [GROUPS],
  output cfg_word_t a_val [GROUPS],
  output cfg_word_t d_val [GROUPS],
  output cfg_word_t b_val [GROUPS][N_BIAS]
);

  cfg_slot_e slot;
  cfg_slot_e slot_next;
  bias_pos_t b_idx;
  logic      wr_en;
  logic      wr_bias;

  // a restart in the same cycle as a beat drops that beat
  assign wr_en   = cfg_valid && !cfg_restart;
  assign wr_bias = slot inside {[SLOT_B_CM:SLOT_B_RB]};
  assign b_idx   = bias_pos_t'(slot - SLOT_B_CM);

  // next slot, only moves on a config beat
  always_comb begin
    slot_next = slot;
    if (cfg_valid) begin
      unique case (slot)
        SLOT_D:    slot_next = SLOT_A;
        SLOT_A:    slot_next = SLOT_B_CM;
        SLOT_B_CM: slot_next = cfg_1x1 ? SLOT_D : SLOT_B_CT;  // 1x1 stops after centre
        SLOT_B_RB: slot_next = SLOT_D;
        default:   slot_next = cfg_slot_e'(slot + 4'd1);  // walk through the edge biases
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      slot <= SLOT_D;
    end else if (cfg_restart) begin
      slot <= SLOT_D;
    end else begin
      slot <= slot_next;
    end
  end

  // per-group value registers, each beat lands in the current slot
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int g = 0; g < GROUPS; g++) begin
        a_val[g] <= '0;
        d_val[g] <= '0;
        for (int b = 0; b < N_BIAS; b++) begin
          b_val[g][b] <= '0;
        end
      end
    end else if (wr_en) begin
      for (int g = 0; g < GROUPS; g++) begin
        if (slot == SLOT_D) begin
          d_val[g] <= cfg_data[g];
        end else if (slot == SLOT_A) begin
          a_val[g] <= cfg_data[g];
        end else if (wr_bias) begin
          b_val[g][b_idx] <= cfg_data[g];
        end
      end
    end
  end

endmodule

// File: lrelu_cfg_pkg.sv
package lrelu_cfg_pkg;

  // one config value per group, A in fixed point, B and D integer
  typedef logic signed [15:0] cfg_word_t;

  // load order of the config slots
  typedef enum logic [3:0] {
    SLOT_D,
    SLOT_A,
    SLOT_B_CM,  // centre, also the only bias in 1x1 mode
    SLOT_B_CT,
    SLOT_B_CB,
    SLOT_B_LM,
    SLOT_B_LT,
    SLOT_B_LB,
    SLOT_B_RM,
    SLOT_B_RT,
    SLOT_B_RB
  } cfg_slot_e;

  // bias index, equal to slot minus SLOT_B_CM
  typedef logic [3:0] bias_pos_t;

  localparam int N_BIAS = 9;

  // column bases, the row offset is added on top
  localparam bias_pos_t POS_CM = 4'd0;
  localparam bias_pos_t POS_LM = 4'd3;
  localparam bias_pos_t POS_RM = 4'd6;
  localparam bias_pos_t OFS_T  = 4'd1;  // top row
  localparam bias_pos_t OFS_B  = 4'd2;  // bottom row

endpackage

// File: lrelu_data_pkg.sv
package lrelu_data_pkg;

  // raw convolution result, one per unit
  typedef logic signed [15:0] in_word_t;

  typedef logic signed [7:0] out_word_t;  // final saturated word

  // x*A needs 32 bits; the rest is headroom for bias, slope and offset
  typedef logic signed [39:0] acc_t;

  // side-band flags carried with every beat
  typedef logic [5:0] user_t;

  // flag bit positions inside user_t
  localparam int I_IS_LRELU  = 0;  // layer uses leaky relu
  localparam int I_IS_TOP    = 1;  // block touches top image edge
  localparam int I_IS_BOTTOM = 2;  // block touches bottom image edge
  localparam int I_IS_1X1    = 3;  // 1x1 kernel, centre bias only
  localparam int I_IS_LEFT   = 4;  // leftmost column
  localparam int I_IS_RIGHT  = 5;  // rightmost column

  // clamp limits for the signed 8-bit output
  localparam int OUT_MAX = 127;
  localparam int OUT_MIN = -128;

endpackage

// File: lrelu_datapath.sv
module lrelu_datapath
  import lrelu_data_pkg::*, lrelu_cfg_pkg::*;
#(
  parameter int GROUPS    = 2,
  parameter int UNITS     = 4,
  parameter int FRAC_BITS = 8,
  parameter int ALPHA     = 26
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      dec_valid,
  input  in_word_t  dec_data [GROUPS][UNITS],
  input  user_t     dec_user,
  input  bias_pos_t dec_pos [UNITS],
  input  cfg_word_t a_val [GROUPS],
  input  cfg_word_t b_val [GROUPS][N_BIAS],
  input  cfg_word_t d_val [GROUPS],
  output logic      m_valid,
  output out_word_t m_data [GROUPS][UNITS],
  output user_t     m_user
);

  // stage registers
  acc_t  s1_acc [GROUPS][UNITS];
  acc_t  s2_acc [GROUPS][UNITS];
  logic  s1_valid;
  logic  s2_valid;
  user_t s1_user;
  user_t s2_user;

  // combinational results feeding each stage
  acc_t      y1 [GROUPS][UNITS];
  acc_t      y2 [GROUPS][UNITS];
  acc_t      y3 [GROUPS][UNITS];
  out_word_t y_sat [GROUPS][UNITS];

  function automatic out_word_t saturate(input acc_t v);
    out_word_t r;
    if (v > OUT_MAX) begin
      r = out_word_t'(OUT_MAX);
    end else if (v < OUT_MIN) begin
      r = out_word_t'(OUT_MIN);
    end else begin
      r = out_word_t'(v);
    end
    return r;
  endfunction

  always_comb begin
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        // x*A back to integer scale, then the position bias
        y1[g][u] = ((acc_t'(dec_data[g][u]) * acc_t'(a_val[g])) >>> FRAC_BITS)
                 + acc_t'(b_val[g][dec_pos[u]]);
        // leaky slope on negatives only
        if (s1_user[I_IS_LRELU] && s1_acc[g][u] < 0) begin
          y2[g][u] = (s1_acc[g][u] * acc_t'(ALPHA)) >>> FRAC_BITS;
        end else begin
          y2[g][u] = s1_acc[g][u];
        end
        y3[g][u]    = s2_acc[g][u] + acc_t'(d_val[g]);
        y_sat[g][u] = saturate(y3[g][u]);
      end
    end
  end

  // valid chain, one flop per stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      m_valid  <= 1'b0;
    end else begin
      s1_valid <= dec_valid;
      s2_valid <= s1_valid;
      m_valid  <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_acc  <= y1;
    s1_user <= dec_user;
    s2_acc  <= y2;
    s2_user <= s1_user;
    m_data  <= y_sat;
    m_user  <= s2_user;  // flags leave untouched
  end

endmodule

// File: lrelu_engine.sv
module lrelu_engine
  import lrelu_data_pkg::*, lrelu_cfg_pkg::*;
#(
  parameter int GROUPS    = 2,
  parameter int UNITS     = 4,
  parameter int FRAC_BITS = 8,
  parameter int ALPHA     = 26
) (
  input  logic      clk,
  input  logic      rst_n,
  // config load
  input  logic      cfg_valid,
  input  cfg_word_t cfg_data [GROUPS],
  input  logic      cfg_1x1,
  input  logic      cfg_restart,
  // input beats
  input  logic      s_valid,
  input  in_word_t  s_data [GROUPS][UNITS],
  input  user_t     s_user,
  // results, 4 cycles behind s_valid
  output logic      m_valid,
  output out_word_t m_data [GROUPS][UNITS],
  output user_t     m_user
);

  cfg_word_t a_val [GROUPS];
  cfg_word_t d_val [GROUPS];
  cfg_word_t b_val [GROUPS][N_BIAS];

  logic      dec_valid;
  in_word_t  dec_data [GROUPS][UNITS];
  user_t     dec_user;
  bias_pos_t dec_pos [UNITS];

  cfg_loader #(
    .GROUPS (GROUPS)
  ) u_cfg_loader (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_valid   (cfg_valid),
    .cfg_1x1     (cfg_1x1),
    .cfg_restart (cfg_restart),
    .cfg_data    (cfg_data),
    .a_val       (a_val),
    .d_val       (d_val),
    .b_val       (b_val)
  );

  position_decoder #(
    .GROUPS (GROUPS),
    .UNITS  (UNITS)
  ) u_position_decoder (
    .clk       (clk),
    .rst_n     (rst_n),
    .s_valid   (s_valid),
    .s_data    (s_data),
    .s_user    (s_user),
    .dec_valid (dec_valid),
    .dec_data  (dec_data),
    .dec_user  (dec_user),
    .dec_pos   (dec_pos)
  );

  lrelu_datapath #(
    .GROUPS    (GROUPS),
    .UNITS     (UNITS),
    .FRAC_BITS (FRAC_BITS),
    .ALPHA     (ALPHA)
  ) u_lrelu_datapath (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec_data  (dec_data),
    .dec_user  (dec_user),
    .dec_pos   (dec_pos),
    .a_val     (a_val),
    .b_val     (b_val),
    .d_val     (d_val),
    .m_valid   (m_valid),
    .m_data    (m_data),
    .m_user    (m_user)
  );

endmodule

// File: lrelu_engine_chk.sv
module lrelu_engine_chk
  import lrelu_data_pkg::*;
#(
  parameter int GROUPS = 2,
  parameter int UNITS  = 4
) (
  input logic      clk,
  input logic      rst_n,
  input logic      s_valid,
  input logic      m_valid,
  input out_word_t m_data [GROUPS][UNITS]
);

  // a reset cycle always leaves the output strobe cleared
  valid_low_in_reset: assert property (@(posedge clk) !rst_n |=> !m_valid)
    else $error("m_valid high while rst_n is low");

  // fixed pipeline depth, decoder plus three datapath stages
  valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid == $past(s_valid, 4))
    else $error("m_valid does not follow s_valid by 4 cycles");

  for (genvar g = 0; g < GROUPS; g++) begin : g_grp
    for (genvar u = 0; u < UNITS; u++) begin : g_unit
      data_known: assert property (@(posedge clk) disable iff (!rst_n)
        m_valid |-> !$isunknown(m_data[g][u]))
        else $error("m_data[%0d][%0d] unknown while m_valid is high", g, u);
    end
  end

endmodule

bind lrelu_engine lrelu_engine_chk #(
  .GROUPS (GROUPS),
  .UNITS  (UNITS)
) u_chk (
  .clk     (clk),
  .rst_n   (rst_n),
  .s_valid (s_valid),
  .m_valid (m_valid),
  .m_data  (m_data)
);

// File: position_decoder.sv
module position_decoder
  import lrelu_data_pkg::*, lrelu_cfg_pkg::*;
#(
  parameter int GROUPS = 2,
  parameter int UNITS  = 4
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      s_valid,
  input  in_word_t  s_data [GROUPS][UNITS],
  input  user_t     s_user,
  output logic      dec_valid,
  output in_word_t  dec_data [GROUPS][UNITS],
  output user_t     dec_user,
  output bias_pos_t dec_pos [UNITS]
);

  bias_pos_t col_base;
  bias_pos_t pos_next [UNITS];

  // left wins over right if both are set
  always_comb begin
    if (s_user[I_IS_LEFT]) begin
      col_base = POS_LM;
    end else if (s_user[I_IS_RIGHT]) begin
      col_base = POS_RM;
    end else begin
      col_base = POS_CM;
    end
  end

  // only the first unit sees the top edge and only the last one the bottom
  always_comb begin
    for (int u = 0; u < UNITS; u++) begin
      if (s_user[I_IS_1X1]) begin
        pos_next[u] = POS_CM;
      end else if (s_user[I_IS_TOP] && u == 0) begin
        pos_next[u] = col_base + OFS_T;
      end else if (s_user[I_IS_BOTTOM] && u == UNITS - 1) begin
        pos_next[u] = col_base + OFS_B;
      end else begin
        pos_next[u] = col_base;  // middle row
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= s_valid;
    end
  end

  // payload, held between beats
  always_ff @(posedge clk) begin
    if (s_valid) begin
      dec_data <= s_data;
      dec_user <= s_user;
      dec_pos  <= pos_next;
    end
  end

endmodule

// File: tb_lrelu_engine.sv
module tb_lrelu_engine
  import lrelu_data_pkg::*, lrelu_cfg_pkg::*;
();

  localparam int GROUPS      = 2;
  localparam int UNITS       = 4;
  localparam int FRAC_BITS   = 8;
  localparam int ALPHA       = 26;
  localparam int LATENCY     = 4;   // s_valid edge to m_valid edge
  localparam int DRIVE_DLY   = 10;
  localparam int DRAIN_LIMIT = 50;

  logic      clk;
  logic      rst_n;
  logic      cfg_valid;
  cfg_word_t cfg_data [GROUPS];
  logic      cfg_1x1;
  logic      cfg_restart;
  logic      s_valid;
  in_word_t  s_data [GROUPS][UNITS];
  user_t     s_user;
  logic      m_valid;
  out_word_t m_data [GROUPS][UNITS];
  user_t     m_user;

  // reference copy of the loaded config and the values for the next load
  cfg_word_t ref_a [GROUPS];
  cfg_word_t ref_d [GROUPS];
  cfg_word_t ref_b [GROUPS][N_BIAS];
  cfg_word_t new_a [GROUPS];
  cfg_word_t new_d [GROUPS];
  cfg_word_t new_b [GROUPS][N_BIAS];
  int        ref_slot;
  in_word_t  beat_x [GROUPS][UNITS];

  logic [GROUPS*UNITS*8-1:0] exp_data_q [$];
  user_t                     exp_user_q [$];
  int                        exp_cycle_q [$];

  logic [31:0] lcg_state = 32'h92df_938b;
  int          cycle;
  int          errors;
  int          checks;
  int          beats_done;
  int          err_mark;
  int          beat_mark;
  bit          timed_out;

  lrelu_engine UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_valid   (cfg_valid),
    .cfg_data    (cfg_data),
    .cfg_1x1     (cfg_1x1),
    .cfg_restart (cfg_restart),
    .s_valid     (s_valid),
    .s_data      (s_data),
    .s_user      (s_user),
    .m_valid     (m_valid),
    .m_data      (m_data),
    .m_user      (m_user)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    int span;
    span = hi - lo + 1;
    return lo + int'((lcg_next() >> 8) % span);  // skip the weak low bits
  endfunction

  // expected output word of one unit
  function automatic out_word_t ref_result(input int g, input int u, input in_word_t x,
                                           input user_t usr);
    int     col;
    int     row;
    longint y;
    col = 0;
    row = 0;
    if (!usr[I_IS_1X1]) begin
      if (usr[I_IS_LEFT]) col = 1;
      else if (usr[I_IS_RIGHT]) col = 2;
      if (usr[I_IS_TOP] && u == 0) row = 1;
      else if (usr[I_IS_BOTTOM] && u == UNITS - 1) row = 2;
    end
    y = ((longint'(x) * longint'(ref_a[g])) >>> FRAC_BITS) + longint'(ref_b[g][col * 3 + row]);
    if (usr[I_IS_LRELU] && y < 0) y = (y * ALPHA) >>> FRAC_BITS;
    y = y + longint'(ref_d[g]);
    if (y > OUT_MAX) return out_word_t'(OUT_MAX);
    if (y < OUT_MIN) return out_word_t'(OUT_MIN);
    return out_word_t'(y);
  endfunction

  function automatic user_t edge_flags(input int i);
    user_t f;
    f = '0;
    f[I_IS_TOP]    = i[0];
    f[I_IS_BOTTOM] = i[1];
    f[I_IS_LEFT]   = i[2];
    f[I_IS_RIGHT]  = i[3];
    return f;
  endfunction

  task automatic check_data(input string name, input out_word_t got, input out_word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_user(input user_t got, input user_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: m_user got 0x%02h expected 0x%02h", $time, got, exp);
    end
  endtask

  task automatic tick();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // one config beat into the slot the reference says is current
  task automatic cfg_beat();
    for (int g = 0; g < GROUPS; g++) begin
      if (ref_slot == SLOT_D) begin
        cfg_data[g] = new_d[g];
        ref_d[g]    = new_d[g];
      end else if (ref_slot == SLOT_A) begin
        cfg_data[g] = new_a[g];
        ref_a[g]    = new_a[g];
      end else begin
        cfg_data[g]                      = new_b[g][ref_slot - SLOT_B_CM];
        ref_b[g][ref_slot - SLOT_B_CM] = new_b[g][ref_slot - SLOT_B_CM];
      end
    end
    cfg_valid = 1'b1;
    if (ref_slot == SLOT_B_CM && cfg_1x1) ref_slot = SLOT_D;
    else if (ref_slot == SLOT_B_RB) ref_slot = SLOT_D;
    else ref_slot++;
    tick();
    cfg_valid = 1'b0;
  endtask

  task automatic load_config(input logic one_by_one);
    cfg_1x1 = one_by_one;
    repeat (one_by_one ? 3 : N_BIAS + 2) cfg_beat();
  endtask

  task automatic restart_config();
    cfg_restart = 1'b1;
    tick();
    cfg_restart = 1'b0;
    ref_slot    = SLOT_D;
  endtask

  task automatic set_values(input int a, input int d, input int b0, input int b_step);
    for (int g = 0; g < GROUPS; g++) begin
      new_a[g] = cfg_word_t'(a - g * 32);
      new_d[g] = cfg_word_t'(d + g);
      for (int k = 0; k < N_BIAS; k++) new_b[g][k] = cfg_word_t'(b0 + k * b_step + g * 3);
    end
  endtask

  task automatic random_values();
    for (int g = 0; g < GROUPS; g++) begin
      new_a[g] = cfg_word_t'(rand_range(-512, 512));
      new_d[g] = cfg_word_t'(rand_range(-20, 20));
      for (int k = 0; k < N_BIAS; k++) new_b[g][k] = cfg_word_t'(rand_range(-60, 60));
    end
  endtask

  task automatic fill_random_x(input int lo, input int hi);
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) beat_x[g][u] = in_word_t'(rand_range(lo, hi));
    end
  endtask

  task automatic send_beat(input user_t usr);
    logic [GROUPS*UNITS*8-1:0] flat;
    for (int g = 0; g < GROUPS; g++) begin
      for (int u = 0; u < UNITS; u++) begin
        s_data[g][u]               = beat_x[g][u];
        flat[(g*UNITS+u)*8 +: 8] = ref_result(g, u, beat_x[g][u], usr);
      end
    end
    s_user  = usr;
    s_valid = 1'b1;
    exp_data_q.push_back(flat);
    exp_user_q.push_back(usr);
    exp_cycle_q.push_back(cycle);
    tick();
    s_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_cycle_q.size() > 0 && n < DRAIN_LIMIT) begin
      tick();
      n++;
    end
    if (exp_cycle_q.size() > 0) begin
      $display("timeout: %0d results still missing after %0d cycles", exp_cycle_q.size(), n);
      timed_out = 1'b1;
    end
  endtask

  task automatic mark_test();
    err_mark  = errors;
    beat_mark = beats_done;
  endtask

  task automatic report_test(input string name);
    $display("[%0t] %s: %0d beats checked, %0d errors", $time, name,
             beats_done - beat_mark, errors - err_mark);
  endtask

  // compares every result beat against the oldest expected one
  always @(negedge clk) begin : compare_proc
    logic [GROUPS*UNITS*8-1:0] exp_flat;
    user_t                     exp_usr;
    int                        lat;
    if (!rst_n && m_valid !== 1'b0) begin
      errors++;
      $display("m_valid is not low at %0t while reset is asserted", $time);
    end else if (rst_n && m_valid) begin
      if (exp_cycle_q.size() == 0) begin
        errors++;
        $display("m_valid at %0t with no beat outstanding", $time);
      end else begin
        exp_flat = exp_data_q.pop_front();
        exp_usr  = exp_user_q.pop_front();
        lat      = cycle - exp_cycle_q.pop_front();
        if (lat != LATENCY) begin
          errors++;
          $display("result at %0t came %0d cycles after its beat, not %0d", $time, lat, LATENCY);
        end
        for (int g = 0; g < GROUPS; g++) begin
          for (int u = 0; u < UNITS; u++) begin
            check_data($sformatf("m_data[%0d][%0d]", g, u), m_data[g][u],
                       out_word_t'(exp_flat[(g*UNITS+u)*8 +: 8]));
          end
        end
        check_user(m_user, exp_usr);
        beats_done++;
      end
    end else if (rst_n && exp_cycle_q.size() > 0 && cycle - exp_cycle_q[0] >= LATENCY) begin
      errors++;
      $display("beat sent in cycle %0d gave no m_valid by %0t", exp_cycle_q[0], $time);
      void'(exp_data_q.pop_front());
      void'(exp_user_q.pop_front());
      void'(exp_cycle_q.pop_front());
    end
  end

  task automatic edge_bias_sweep();
    mark_test();
    set_values(256, 2, 5, 9);  // distinct bias per position
    load_config(1'b0);
    for (int i = 0; i < 16; i++) begin
      fill_random_x(-20, 20);
      send_beat(edge_flags(i));
    end
    wait_drain();
    report_test("3x3 edge biases");
  endtask

  task automatic centre_only_mode();
    user_t usr;
    mark_test();
    set_values(384, -3, -30, 7);
    load_config(1'b1);
    for (int i = 0; i < 8; i++) begin
      fill_random_x(-30, 30);
      usr            = edge_flags(i * 2 + 1);
      usr[I_IS_1X1] = 1'b1;
      send_beat(usr);
    end
    wait_drain();
    set_values(384, 11, -30, 7);
    cfg_beat();  // fourth beat wraps to D
    for (int i = 0; i < 8; i++) begin
      fill_random_x(-30, 30);
      usr            = edge_flags(15 - i);
      usr[I_IS_1X1] = 1'b1;
      send_beat(usr);
    end
    wait_drain();
    restart_config();
    report_test("1x1 mode");
  endtask

  task automatic leaky_slope();
    user_t usr;
    mark_test();
    set_values(128, 4, -10, 2);
    load_config(1'b0);
    for (int i = 0; i < 16; i++) begin
      fill_random_x(-400, 400);
      usr              = edge_flags(i >> 1);
      usr[I_IS_LRELU] = i[0];
      send_beat(usr);
    end
    wait_drain();
    report_test("leaky relu");
  endtask

  task automatic clamp_limits();
    user_t usr;
    int    v;
    mark_test();
    set_values(16384, 0, 0, 1);  // A of 64.0
    load_config(1'b0);
    for (int i = 0; i < 10; i++) begin
      for (int g = 0; g < GROUPS; g++) begin
        for (int u = 0; u < UNITS; u++) begin
          v            = rand_range(300, 3000);
          beat_x[g][u] = in_word_t'(((g + u + i) % 2 == 1) ? v : -v);
        end
      end
      usr              = edge_flags(i);
      usr[I_IS_LRELU] = (i % 3 == 0);
      send_beat(usr);
    end
    wait_drain();
    report_test("saturation");
  endtask

  task automatic random_stream();
    mark_test();
    random_values();
    load_config(1'b0);
    for (int i = 0; i < 48; i++) begin
      if (rand_range(0, 3) == 0) tick();  // occasional gap
      fill_random_x(-2000, 2000);
      send_beat(user_t'(lcg_next() >> 11));
    end
    wait_drain();
    report_test("random streaming");
  endtask

  task automatic restart_reload();
    user_t usr;
    mark_test();
    set_values(500, 9, -70, 5);
    cfg_1x1 = 1'b0;
    repeat (5) cfg_beat();  // stop inside the edge biases
    restart_config();
    set_values(300, -6, 40, -8);
    load_config(1'b0);
    for (int i = 0; i < 16; i++) begin
      fill_random_x(-40, 40);
      usr              = edge_flags(i);
      usr[I_IS_LRELU] = i[2];
      send_beat(usr);
    end
    wait_drain();
    report_test("restart");
  endtask

  initial begin
    cfg_valid   = 1'b0;
    cfg_1x1     = 1'b0;
    cfg_restart = 1'b0;
    s_valid     = 1'b0;
    s_user      = '0;
    for (int g = 0; g < GROUPS; g++) begin
      cfg_data[g] = '0;
      ref_a[g]    = '0;
      ref_d[g]    = '0;
      for (int k = 0; k < N_BIAS; k++) ref_b[g][k] = '0;
      for (int u = 0; u < UNITS; u++) s_data[g][u] = '0;
    end
    ref_slot   = SLOT_D;
    errors     = 0;
    checks     = 0;
    beats_done = 0;
    timed_out  = 1'b0;
    rst_n      = 1'b0;
    repeat (4) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    tick();
    if (!timed_out) edge_bias_sweep();
    if (!timed_out) centre_only_mode();
    if (!timed_out) leaky_slope();
    if (!timed_out) clamp_limits();
    if (!timed_out) random_stream();
    if (!timed_out) restart_reload();
    $display("summary: %0d beats, %0d checks, %0d errors", beats_done, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
